//--- verif/ctrlport_periph_stim.txt
# op addr data byte_en has_time time_offset expected_status expected_data (all hex)
# op: w write, r read, g write LFSR data, c read against scratch model, t check time
g 00000 0 f 0 0 0 0
g 00004 0 f 0 0 0 0
g 00008 0 f 0 0 0 0
g 0000c 0 f 0 0 0 0
c 00000 0 0 0 0 0 0
c 00004 0 0 0 0 0 0
c 00008 0 0 0 0 0 0
c 0000c 0 0 0 0 0 0
w 00004 a5a5a5a5 5 0 0 0 0
c 00004 0 0 0 0 0 0
w 00008 12345678 8 0 0 0 0
c 00008 0 0 0 0 0 0
w 00108 00001000 f 0 0 0 0
w 0010c 00000002 f 0 0 0 0
t 00100 0 0 0 0 0 0
w 0000c cafef00d f 1 3e8 0 0
c 0000c 0 0 0 0 0 0
w 00108 00abcdef f 1 28 0 0
r 00108 0 0 0 0 0 00abcdef
w 00108 deadbeef f 1 ffffffffffffff00 2 0
r 00108 0 0 0 0 0 00abcdef
r 00200 0 0 0 0 1 0
w 00200 55555555 f 0 0 1 0
w 00110 11111111 f 0 0 1 0
r 00110 0 0 0 0 1 0

//--- ctrlport_periph_top.f
hw/ctrlport_pkg.sv
hw/periph_map_pkg.sv
hw/ctrlport_splitter.sv
hw/scratch_regs.sv
hw/timekeeper_regs.sv
hw/unmapped_responder.sv
hw/ctrlport_periph_top.sv
verif/ctrlport_periph_chk.sv
verif/ctrlport_periph_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = ctrlport_periph_tb
FILELIST = ctrlport_periph_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = TEST OK

SRCS = $(shell cat $(FILELIST)) verif/ctrlport_periph_stim.txt
EXE  = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(EXE) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/ctrlport_periph_tb.sv
// ------------------------------
// Testbench for the control-port peripheral subsystem: replays stimulus
// records through the master port and checks every response
// ------------------------------

module ctrlport_periph_tb import ctrlport_pkg::*, periph_map_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    ack_timeout = 200;
  localparam string stim_path   = "verif/ctrlport_periph_stim.txt";

  logic                       ctrlport_clk = 1'b0;
  logic                       ctrlport_rst;
  logic                       req_wr;
  logic                       req_rd;
  logic [ctrlport_addr_w-1:0] req_addr;
  logic [ctrlport_data_w-1:0] req_data;
  logic [ctrlport_be_w-1:0]   req_byte_en;
  logic                       req_has_time;
  logic [ctrlport_time_w-1:0] req_time;
  logic                       resp_ack;
  ctrlport_status_t           resp_status;
  logic [ctrlport_data_w-1:0] resp_data;

  int          cycle_cnt = 0;
  int          mismatch_errs = 0;
  int          other_errs = 0;
  int          timeout_errs = 0;
  logic [31:0] lfsr_state = 32'd43;
  // Reference copy of the scratch bank and of the last time load
  logic [31:0] scratch_model [scratch_words];
  logic [31:0] set_lo_shadow = '0;
  logic [63:0] loaded_time = '0;
  int          load_cycle = 0;

  ctrlport_periph_top #(.num_slaves(3)) ctrlport_periph_top_inst (.*);

  always #50 ctrlport_clk = ~ctrlport_clk;

  // Posedge count, read only at falling edges where it is stable
  always @(posedge ctrlport_clk) cycle_cnt <= cycle_cnt + 1;

  // ------------------------------
  // Helpers
  // ------------------------------

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per data bit taken
  task automatic random_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      w[i]       = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic logic is_time_addr(input logic [19:0] addr);
    return addr >= time_base && addr < time_base + 20'h10;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
      mismatch_errs++;
    end
  endtask

  // Issues one strobe and waits for its ack, latency counts falling edges
  task automatic do_request(input logic wr, input logic [19:0] addr,
                            input logic [31:0] data, input logic [3:0] be,
                            input logic has_time, input logic [63:0] rtime,
                            output logic [1:0] status, output logic [31:0] rdata,
                            output int strobe_cyc, output int latency);
    @(negedge ctrlport_clk);
    req_wr       = wr;
    req_rd       = ~wr;
    req_addr     = addr;
    req_data     = data;
    req_byte_en  = be;
    req_has_time = has_time;
    req_time     = rtime;
    strobe_cyc   = cycle_cnt;
    @(negedge ctrlport_clk);
    req_wr  = 1'b0;
    req_rd  = 1'b0;
    latency = 1;
    while (resp_ack !== 1'b1 && latency < ack_timeout) begin
      @(negedge ctrlport_clk);
      latency++;
    end
    status = resp_status;
    rdata  = resp_data;
    if (resp_ack !== 1'b1) begin
      $display("ERROR: no acknowledgement for address 0x%05h within %0d cycles",
               addr, ack_timeout);
      timeout_errs++;
    end
  endtask

  // Coherent 64-bit read, the low word latches the high word
  task automatic read_time(output logic [63:0] t, output int lo_cyc);
    logic [1:0]  st;
    logic [31:0] lo;
    logic [31:0] hi;
    int          cyc;
    int          lat;
    do_request(1'b0, time_base + time_lo_ofs, '0, '0, 1'b0, '0, st, lo, lo_cyc, lat);
    do_request(1'b0, time_base + time_hi_ofs, '0, '0, 1'b0, '0, st, hi, cyc, lat);
    t = {hi, lo};
  endtask

  // Counter may only have advanced by the cycles since the load strobe
  task automatic check_loaded_time();
    logic [63:0] t;
    logic [63:0] upper;
    int          lo_cyc;
    read_time(t, lo_cyc);
    upper = loaded_time + 64'(lo_cyc - load_cycle);
    if (timeout_errs == 0 && (t < loaded_time || t > upper)) begin
      $display("ERROR: time 0x%0h read outside the window 0x%0h to 0x%0h",
               t, loaded_time, upper);
      other_errs++;
    end
  endtask

  // ------------------------------
  // Record execution
  // ------------------------------

  task automatic run_record(input logic [7:0] op, input logic [19:0] addr,
                            input logic [31:0] data, input logic [3:0] be,
                            input logic has_time, input logic [63:0] offset,
                            input logic [1:0] exp_status, input logic [31:0] exp_data);
    logic        wr;
    logic [31:0] wdata;
    logic [63:0] now;
    logic [63:0] rtime;
    logic [1:0]  status;
    logic [31:0] rdata;
    int          strobe_cyc;
    int          latency;
    int          time_cyc;
    wr       = (op == "w" || op == "g");
    wdata    = data;
    rtime    = '0;
    time_cyc = 0;
    if (op == "g") begin
      random_word(wdata);
    end
    if (op == "t") begin
      check_loaded_time();
    end else begin
      // Timed requests are placed relative to the counter as read now
      if (has_time) begin
        read_time(now, time_cyc);
        rtime = now + offset;
      end
      do_request(wr, addr, wdata, be, has_time, rtime, status, rdata, strobe_cyc, latency);
      if (timeout_errs == 0) begin
        check_value("resp_status", exp_status, status);
        if (op == "c") begin
          check_value("resp_data", scratch_model[addr[3:2]], rdata);
        end else begin
          check_value("resp_data", exp_data, rdata);
        end
        // Only a held timekeeper request has a variable latency
        if (has_time && is_time_addr(addr) && exp_status == sts_okay) begin
          if (64'(cycle_cnt - time_cyc) < offset) begin
            $display("ERROR: timed request to 0x%05h acknowledged before its time", addr);
            other_errs++;
          end
        end else begin
          check_value("ack_latency", 2, latency);
        end
      end
      if (wr && exp_status == sts_okay) begin
        if (addr < scratch_base + 4 * scratch_words) begin
          for (int b = 0; b < 4; b++) begin
            if (be[b]) scratch_model[addr[3:2]][8*b +: 8] = wdata[8*b +: 8];
          end
        end
        if (addr == time_base + time_set_lo_ofs) set_lo_shadow = wdata;
        if (addr == time_base + time_set_hi_ofs) begin
          loaded_time = {wdata, set_lo_shadow};
          load_cycle  = strobe_cyc;
        end
      end
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [19:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    logic        has_time;
    logic [63:0] offset;
    logic [1:0]  exp_status;
    logic [31:0] exp_data;
    ctrlport_rst = 1'b1;
    req_wr       = 1'b0;
    req_rd       = 1'b0;
    req_addr     = '0;
    req_data     = '0;
    req_byte_en  = '0;
    req_has_time = 1'b0;
    req_time     = '0;
    for (int w = 0; w < scratch_words; w++) begin
      scratch_model[w] = '0;
    end
    repeat (2) @(negedge ctrlport_clk);
    ctrlport_rst = 1'b0;
    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the stimulus file %s", stim_path);
      other_errs++;
    end else begin
      // A timeout leaves the handshake in an unknown state, so stop there
      while (!$feof(fd) && timeout_errs == 0) begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h %h %h %h %h %h", op, addr, data, be,
                      has_time, offset, exp_status, exp_data);
          if (n != 8) begin
            $display("ERROR: malformed stimulus line: %s", line);
            other_errs++;
          end else begin
            run_record(op, addr, data, be, has_time, offset, exp_status, exp_data);
          end
        end
      end
      $fclose(fd);
    end
    $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
             mismatch_errs, other_errs, timeout_errs);
    if (mismatch_errs + other_errs + timeout_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verif/ctrlport_periph_chk.sv
// ------------------------------
// Handshake assertions bound into the control-port splitter
// ------------------------------

module ctrlport_periph_chk #(
  parameter int num_slaves = 2
) (
  input logic                  ctrlport_clk,
  input logic                  ctrlport_rst,
  input logic [num_slaves-1:0] m_resp_ack,
  input logic                  s_resp_ack
);
  timeunit 1ns;
  timeprecision 1ps;

  // Each request is claimed by exactly one slave
  one_slave_ack: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    $onehot0(m_resp_ack))
    else $error("more than one slave acknowledged in the same cycle");

  // The merged ack is a plain one-cycle register of the slave acks
  ack_forwarded: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    (|m_resp_ack) |=> s_resp_ack)
    else $error("slave ack was not forwarded one cycle later");

  ack_has_source: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    s_resp_ack |-> $past(|m_resp_ack))
    else $error("master ack without a slave ack one cycle earlier");

  // Synchronous reset, so acks are low from the cycle after it is sampled
  quiet_in_reset: assert property (@(posedge ctrlport_clk)
    ctrlport_rst |=> (m_resp_ack == '0 && !s_resp_ack))
    else $error("ack high while reset is applied");

endmodule

bind ctrlport_splitter ctrlport_periph_chk #(
  .num_slaves (num_slaves)
) chk_inst (
  .ctrlport_clk (ctrlport_clk),
  .ctrlport_rst (ctrlport_rst),
  .m_resp_ack   (m_resp_ack),
  .s_resp_ack   (s_resp_ack)
);

//--- hw/ctrlport_periph_top.sv
// ----------------------------
// Peripheral subsystem top: splitter feeding the scratch bank, the
// timekeeper and the unmapped-address responder
// ----------------------------

module ctrlport_periph_top import ctrlport_pkg::*; #(
  parameter int num_slaves = 3
) (
  input  logic                       ctrlport_clk,
  input  logic                       ctrlport_rst,
  input  logic                       req_wr,
  input  logic                       req_rd,
  input  logic [ctrlport_addr_w-1:0] req_addr,
  input  logic [ctrlport_data_w-1:0] req_data,
  input  logic [ctrlport_be_w-1:0]   req_byte_en,
  input  logic                       req_has_time,
  input  logic [ctrlport_time_w-1:0] req_time,
  output logic                       resp_ack,
  output ctrlport_status_t           resp_status,
  output logic [ctrlport_data_w-1:0] resp_data
);

  localparam int sts_w = $bits(ctrlport_status_t);

  // Per-slave buses, slot 0 scratch, 1 timekeeper, 2 unmapped
  logic [num_slaves-1:0]                 m_req_wr;
  logic [num_slaves-1:0]                 m_req_rd;
  logic [ctrlport_addr_w*num_slaves-1:0] m_req_addr;
  logic [ctrlport_data_w*num_slaves-1:0] m_req_data;
  logic [ctrlport_be_w*num_slaves-1:0]   m_req_byte_en;
  logic [num_slaves-1:0]                 m_req_has_time;
  logic [ctrlport_time_w*num_slaves-1:0] m_req_time;
  logic [num_slaves-1:0]                 m_resp_ack;
  logic [sts_w*num_slaves-1:0]           m_resp_status;
  logic [ctrlport_data_w*num_slaves-1:0] m_resp_data;

  ctrlport_splitter #(
    .num_slaves (num_slaves)
  ) splitter_inst (
    .ctrlport_clk   (ctrlport_clk),
    .ctrlport_rst   (ctrlport_rst),
    .s_req_wr       (req_wr),
    .s_req_rd       (req_rd),
    .s_req_addr     (req_addr),
    .s_req_data     (req_data),
    .s_req_byte_en  (req_byte_en),
    .s_req_has_time (req_has_time),
    .s_req_time     (req_time),
    .s_resp_ack     (resp_ack),
    .s_resp_status  (resp_status),
    .s_resp_data    (resp_data),
    .m_req_wr       (m_req_wr),
    .m_req_rd       (m_req_rd),
    .m_req_addr     (m_req_addr),
    .m_req_data     (m_req_data),
    .m_req_byte_en  (m_req_byte_en),
    .m_req_has_time (m_req_has_time),
    .m_req_time     (m_req_time),
    .m_resp_ack     (m_resp_ack),
    .m_resp_status  (m_resp_status),
    .m_resp_data    (m_resp_data)
  );

  scratch_regs scratch_inst (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (m_req_wr[0]),
    .req_rd       (m_req_rd[0]),
    .req_addr     (m_req_addr[0 +: ctrlport_addr_w]),
    .req_data     (m_req_data[0 +: ctrlport_data_w]),
    .req_byte_en  (m_req_byte_en[0 +: ctrlport_be_w]),
    .resp_ack     (m_resp_ack[0]),
    .resp_status  (m_resp_status[0 +: sts_w]),
    .resp_data    (m_resp_data[0 +: ctrlport_data_w])
  );

  timekeeper_regs timekeeper_inst (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (m_req_wr[1]),
    .req_rd       (m_req_rd[1]),
    .req_addr     (m_req_addr[ctrlport_addr_w +: ctrlport_addr_w]),
    .req_data     (m_req_data[ctrlport_data_w +: ctrlport_data_w]),
    .req_has_time (m_req_has_time[1]),
    .req_time     (m_req_time[ctrlport_time_w +: ctrlport_time_w]),
    .resp_ack     (m_resp_ack[1]),
    .resp_status  (m_resp_status[sts_w +: sts_w]),
    .resp_data    (m_resp_data[ctrlport_data_w +: ctrlport_data_w])
  );

  unmapped_responder unmapped_inst (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (m_req_wr[2]),
    .req_rd       (m_req_rd[2]),
    .req_addr     (m_req_addr[2*ctrlport_addr_w +: ctrlport_addr_w]),
    .resp_ack     (m_resp_ack[2]),
    .resp_status  (m_resp_status[2*sts_w +: sts_w]),
    .resp_data    (m_resp_data[2*ctrlport_data_w +: ctrlport_data_w])
  );

endmodule

//--- hw/unmapped_responder.sv
// ----------------------------
// Catch-all slave that answers unmapped accesses with a command error
// ----------------------------

module unmapped_responder import ctrlport_pkg::*, periph_map_pkg::*; (
  input  logic                       ctrlport_clk,
  input  logic                       ctrlport_rst,
  input  logic                       req_wr,
  input  logic                       req_rd,
  input  logic [ctrlport_addr_w-1:0] req_addr,
  output logic                       resp_ack,
  output ctrlport_status_t           resp_status,
  output logic [ctrlport_data_w-1:0] resp_data
);

  logic unmapped;

  // Claims exactly the complement of the decoded ranges, so every
  // request gets exactly one answer
  assign unmapped = ~in_scratch(req_addr) & ~in_time(req_addr);

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack <= 1'b0;
    end else begin
      resp_ack <= (req_wr | req_rd) & unmapped;
    end
  end

  // Error only while acking, so the idle response stays all zero
  assign resp_status = resp_ack ? sts_cmderr : sts_okay;
  assign resp_data   = '0;

endmodule

//--- hw/timekeeper_regs.sv
// ----------------------------
// Timekeeper: free-running 64-bit time counter with read, set and the
// hold logic that delays timed requests until their time arrives
// ----------------------------

module timekeeper_regs import ctrlport_pkg::*, periph_map_pkg::*; (
  input  logic                       ctrlport_clk,
  input  logic                       ctrlport_rst,
  input  logic                       req_wr,
  input  logic                       req_rd,
  input  logic [ctrlport_addr_w-1:0] req_addr,
  input  logic [ctrlport_data_w-1:0] req_data,
  input  logic                       req_has_time,
  input  logic [ctrlport_time_w-1:0] req_time,
  output logic                       resp_ack,
  output ctrlport_status_t           resp_status,
  output logic [ctrlport_data_w-1:0] resp_data
);

  logic [ctrlport_time_w-1:0] time_now;
  logic [ctrlport_data_w-1:0] time_hi_latch;
  logic [ctrlport_data_w-1:0] set_lo_stage;

  // Pending timed request, at most one since the master waits for ack
  logic                       pend_valid;
  logic                       pend_wr;
  logic [ctrlport_addr_w-1:0] pend_ofs;
  logic [ctrlport_data_w-1:0] pend_data;
  logic [ctrlport_time_w-1:0] pend_time;

  logic                       strobe;
  logic                       late;
  logic                       future;
  logic [ctrlport_addr_w-1:0] req_ofs;
  logic                       pend_go;
  logic                       exec_go;
  logic                       exec_wr;
  logic [ctrlport_addr_w-1:0] exec_ofs;
  logic [ctrlport_data_w-1:0] exec_data;

  // ----------------------------
  // Request classification
  // ----------------------------

  // Offset inside the block, aligned down to a word
  assign req_ofs = {req_addr[ctrlport_addr_w-1:2] - time_base[ctrlport_addr_w-1:2], 2'b00};
  assign strobe  = (req_wr | req_rd) & in_time(req_addr);
  // A time equal to the counter runs now, earlier is late, later is held
  assign late    = req_has_time & (req_time < time_now);
  assign future  = req_has_time & (req_time > time_now);

  // The held request fires in the cycle the counter reaches its time
  assign pend_go   = pend_valid & (time_now == pend_time);
  assign exec_go   = pend_go | (strobe & ~late & ~future);
  assign exec_wr   = pend_go ? pend_wr   : req_wr;
  assign exec_ofs  = pend_go ? pend_ofs  : req_ofs;
  assign exec_data = pend_go ? pend_data : req_data;

  // ----------------------------
  // Counter, pending slot and ack
  // ----------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      time_now   <= '0;
      pend_valid <= 1'b0;
      resp_ack   <= 1'b0;
    end else begin
      // Loading the high word takes the low word from the staging register
      if (exec_go && exec_wr && exec_ofs == time_set_hi_ofs) begin
        time_now <= {exec_data, set_lo_stage};
      end else begin
        time_now <= time_now + 1'b1;
      end
      if (strobe && future) begin
        pend_valid <= 1'b1;
      end else if (pend_go) begin
        pend_valid <= 1'b0;
      end
      // A late request is answered straight away and never executed
      resp_ack <= exec_go | (strobe & late);
    end
  end

  // Captured fields of a held request
  always_ff @(posedge ctrlport_clk) begin
    if (strobe && future) begin
      pend_wr   <= req_wr;
      pend_ofs  <= req_ofs;
      pend_data <= req_data;
      pend_time <= req_time;
    end
  end

  // ----------------------------
  // Register writes and read data
  // ----------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (exec_go && exec_wr && exec_ofs == time_set_lo_ofs) begin
      set_lo_stage <= exec_data;
    end
    // Reading the low word freezes the high word for a coherent 64-bit read
    if (exec_go && !exec_wr && exec_ofs == time_lo_ofs) begin
      time_hi_latch <= time_now[ctrlport_time_w-1:ctrlport_data_w];
    end
  end

  // Status and data stay zero whenever this block does not ack
  always_ff @(posedge ctrlport_clk) begin
    resp_status <= (strobe && late) ? sts_tserr : sts_okay;
    resp_data   <= '0;
    if (exec_go && !exec_wr) begin
      case (exec_ofs)
        time_lo_ofs:     resp_data <= time_now[ctrlport_data_w-1:0];
        time_hi_ofs:     resp_data <= time_hi_latch;
        time_set_lo_ofs: resp_data <= set_lo_stage;
        default:         resp_data <= '0;
      endcase
    end
  end

endmodule

//--- hw/scratch_regs.sv
// ----------------------------
// Scratch register bank: read/write words with byte-enable writes
// ----------------------------

module scratch_regs import ctrlport_pkg::*, periph_map_pkg::*; (
  input  logic                       ctrlport_clk,
  input  logic                       ctrlport_rst,
  input  logic                       req_wr,
  input  logic                       req_rd,
  input  logic [ctrlport_addr_w-1:0] req_addr,
  input  logic [ctrlport_data_w-1:0] req_data,
  input  logic [ctrlport_be_w-1:0]   req_byte_en,
  output logic                       resp_ack,
  output ctrlport_status_t           resp_status,
  output logic [ctrlport_data_w-1:0] resp_data
);

  localparam int idx_w = $clog2(scratch_words);

  logic [ctrlport_data_w-1:0] words [scratch_words];
  logic [ctrlport_addr_w-1:0] ofs;
  logic [idx_w-1:0]           idx;
  logic                       hit;

  // Word index from the byte offset, the low two bits select a byte
  assign ofs = req_addr - scratch_base;
  assign idx = ofs[idx_w+1:2];
  assign hit = in_scratch(req_addr);

  // Every access here succeeds, and okay is also the idle value
  assign resp_status = sts_okay;

  // ----------------------------
  // Register bank and ack
  // ----------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack <= 1'b0;
      for (int w = 0; w < scratch_words; w++) begin
        words[w] <= scratch_reset_value;
      end
    end else begin
      // Timed requests are served at once, the time field is not looked at
      resp_ack <= (req_wr | req_rd) & hit;
      if (req_wr && hit) begin
        for (int b = 0; b < ctrlport_be_w; b++) begin
          if (req_byte_en[b]) begin
            words[idx][8*b +: 8] <= req_data[8*b +: 8];
          end
        end
      end
    end
  end

  // Read data stays zero unless this bank answers a read
  always_ff @(posedge ctrlport_clk) begin
    if (req_rd && hit) begin
      resp_data <= words[idx];
    end else begin
      resp_data <= '0;
    end
  end

endmodule

//--- hw/ctrlport_splitter.sv
// ----------------------------
// Control-port splitter: fans one request out to every slave and merges
// the slave responses into one registered response
// ----------------------------

module ctrlport_splitter import ctrlport_pkg::*; #(
  parameter int num_slaves = 2
) (
  input  logic                                      ctrlport_clk,
  input  logic                                      ctrlport_rst,

  // Request from the single master
  input  logic                                      s_req_wr,
  input  logic                                      s_req_rd,
  input  logic [ctrlport_addr_w-1:0]                s_req_addr,
  input  logic [ctrlport_data_w-1:0]                s_req_data,
  input  logic [ctrlport_be_w-1:0]                  s_req_byte_en,
  input  logic                                      s_req_has_time,
  input  logic [ctrlport_time_w-1:0]                s_req_time,
  output logic                                      s_resp_ack,
  output ctrlport_status_t                          s_resp_status,
  output logic [ctrlport_data_w-1:0]                s_resp_data,

  // Packed per-slave buses, slave i sits at slice i
  output logic [num_slaves-1:0]                     m_req_wr,
  output logic [num_slaves-1:0]                     m_req_rd,
  output logic [ctrlport_addr_w*num_slaves-1:0]     m_req_addr,
  output logic [ctrlport_data_w*num_slaves-1:0]     m_req_data,
  output logic [ctrlport_be_w*num_slaves-1:0]       m_req_byte_en,
  output logic [num_slaves-1:0]                     m_req_has_time,
  output logic [ctrlport_time_w*num_slaves-1:0]     m_req_time,
  input  logic [num_slaves-1:0]                     m_resp_ack,
  input  logic [$bits(ctrlport_status_t)*num_slaves-1:0] m_resp_status,
  input  logic [ctrlport_data_w*num_slaves-1:0]     m_resp_data
);

  localparam int sts_w = $bits(ctrlport_status_t);

  logic                       merged_ack;
  logic [sts_w-1:0]           merged_status;
  logic [ctrlport_data_w-1:0] merged_data;

  // ----------------------------
  // Request fan-out
  // ----------------------------

  // Every slave sees the same request and decodes its own range
  for (genvar i = 0; i < num_slaves; i++) begin : gen_fanout
    assign m_req_wr[i]                                  = s_req_wr;
    assign m_req_rd[i]                                  = s_req_rd;
    assign m_req_addr[ctrlport_addr_w*i +: ctrlport_addr_w] = s_req_addr;
    assign m_req_data[ctrlport_data_w*i +: ctrlport_data_w] = s_req_data;
    assign m_req_byte_en[ctrlport_be_w*i +: ctrlport_be_w]  = s_req_byte_en;
    assign m_req_has_time[i]                            = s_req_has_time;
    assign m_req_time[ctrlport_time_w*i +: ctrlport_time_w] = s_req_time;
  end

  // ----------------------------
  // Response merge
  // ----------------------------

  // Only one slave acks a request, so masking by ack and OR-ing is lossless
  always_comb begin
    merged_ack    = 1'b0;
    merged_status = '0;
    merged_data   = '0;
    for (int s = 0; s < num_slaves; s++) begin
      merged_ack    = merged_ack | m_resp_ack[s];
      merged_status = merged_status |
                      (m_resp_status[sts_w*s +: sts_w] & {sts_w{m_resp_ack[s]}});
      merged_data   = merged_data |
                      (m_resp_data[ctrlport_data_w*s +: ctrlport_data_w] &
                       {ctrlport_data_w{m_resp_ack[s]}});
    end
  end

  // The register cuts the combinational path back to the master
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      s_resp_ack <= 1'b0;
    end else begin
      s_resp_ack <= merged_ack;
    end
  end

  // Status and data are qualified by ack at the master, so they carry no reset
  always_ff @(posedge ctrlport_clk) begin
    s_resp_status <= ctrlport_status_t'(merged_status);
    s_resp_data   <= merged_data;
  end

endmodule

//--- hw/periph_map_pkg.sv
// ----------------------------
// Address map, register offsets and reset values of the peripheral
// subsystem, plus the range checks that every slave decodes against
// ----------------------------

package periph_map_pkg;
  import ctrlport_pkg::*;

  // Scratch bank occupies scratch_words consecutive 32-bit words
  localparam logic [ctrlport_addr_w-1:0] scratch_base = 20'h000;
  localparam int                         scratch_words = 4;

  // Timekeeper block and its register offsets from time_base
  localparam logic [ctrlport_addr_w-1:0] time_base       = 20'h100;
  localparam logic [ctrlport_addr_w-1:0] time_lo_ofs     = 20'h0;
  localparam logic [ctrlport_addr_w-1:0] time_hi_ofs     = 20'h4;
  localparam logic [ctrlport_addr_w-1:0] time_set_lo_ofs = 20'h8;
  localparam logic [ctrlport_addr_w-1:0] time_set_hi_ofs = 20'hC;

  localparam logic [ctrlport_data_w-1:0] scratch_reset_value = 32'h0000_0000;

  // True when the address falls in the scratch bank
  // The subtraction wraps, so addresses below the base fail the compare
  function automatic logic in_scratch(input logic [ctrlport_addr_w-1:0] addr);
    logic [ctrlport_addr_w-1:0] ofs;
    ofs = addr - scratch_base;
    return ofs < 4 * scratch_words;
  endfunction

  // True when the address falls in the timekeeper register block
  function automatic logic in_time(input logic [ctrlport_addr_w-1:0] addr);
    logic [ctrlport_addr_w-1:0] ofs;
    ofs = addr - time_base;
    return ofs < time_set_hi_ofs + 4;
  endfunction

endpackage

//--- hw/ctrlport_pkg.sv
// ----------------------------
// Control-port field widths and response status codes shared by the
// master side, the splitter and every register slave
// ----------------------------

package ctrlport_pkg;

  // ----------------------------
  // Field widths
  // ----------------------------

  // Byte address, 1 MiB window per block
  localparam int ctrlport_addr_w = 20;
  localparam int ctrlport_data_w = 32;
  // Timestamp width used for timed requests and the time counter
  localparam int ctrlport_time_w = 64;
  // One enable per data byte
  localparam int ctrlport_be_w   = ctrlport_data_w / 8;

  // ----------------------------
  // Response status
  // ----------------------------

  // A slave that does not acknowledge drives status zero, which is sts_okay
  typedef enum logic [1:0] {
    sts_okay   = 2'd0,
    sts_cmderr = 2'd1,
    sts_tserr  = 2'd2
  } ctrlport_status_t;

endpackage
